//--- verilog/if_fetch_pkg.sv
// Fetch stage constants: redirect source enum, address widths, trap vector fields, FIFO sizing
package if_fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Address and trap vector widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADDR_W   = 32;
  // Upper bits of mtvec, the vector table is 128-byte aligned
  localparam int MTVEC_W  = 25;
  localparam int IRQ_ID_W = 5;

  // NMI uses a fixed slot in the vector table
  localparam logic [IRQ_ID_W-1:0] NMI_INDEX = 5'd15;

  //////////////////////////////////////////////////////////////////////
  // Prefetch FIFO sizing
  //////////////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 4;
  // Wide enough to hold the value FIFO_DEPTH itself
  localparam int CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int PTR_W      = $clog2(FIFO_DEPTH);

  // Redirect sources selected by the controller
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_NMI = 3'd6
  } pc_mux_e;

endpackage

//--- verilog/if_instr_pkg.sv
// Instruction word widths and the compressed quadrant encoding
package if_instr_pkg;

  // Full and compressed instruction sizes
  localparam int INSTR_W  = 32;
  localparam int CINSTR_W = 16;

  //////////////////////////////////////////////////////////////////////
  // Quadrant of the low two opcode bits
  //////////////////////////////////////////////////////////////////////

  // Q0..Q2 hold 16-bit encodings
  // Q_FULL marks a regular 32-bit instruction
  typedef enum logic [1:0] {
    Q0     = 2'b00,
    Q1     = 2'b01,
    Q2     = 2'b10,
    Q_FULL = 2'b11
  } quadrant_e;

endpackage

//--- verilog/if_fetch_intf.sv
// Push interface from fetch controller to FIFO, pop interface from FIFO to IF/ID register
`timescale 1ns/10ps

interface fetch_push_if;
  import if_fetch_pkg::*;
  import if_instr_pkg::*;

  // One-cycle strobe per accepted bus response
  logic               push;
  logic [ADDR_W-1:0]  push_addr;
  logic [INSTR_W-1:0] push_instr;
  logic               push_err;
  // Empties the buffer on a redirect
  logic               flush;
  // Free slots, already reduced by a push of this cycle
  logic [CNT_W-1:0]   free_cnt;

  modport fetcher (output push, push_addr, push_instr, push_err, flush, input free_cnt);
  modport store (input push, push_addr, push_instr, push_err, flush, output free_cnt);
endinterface

interface fetch_pop_if;
  import if_fetch_pkg::*;
  import if_instr_pkg::*;

  // Head entry of the FIFO
  logic               valid;
  logic [ADDR_W-1:0]  addr;
  logic [INSTR_W-1:0] instr;
  logic               err;
  // Head leaves when valid and pop meet at an edge
  logic               pop;

  modport store (output valid, addr, instr, err, input pop);
  modport taker (input valid, addr, instr, err, output pop);
endinterface

//--- verilog/if_pc_fetch.sv
// Fetch controller: next-PC select, bus requests, outstanding and discard counters
`timescale 1ns/10ps

module if_pc_fetch (
  input  logic                                clk,
  input  logic                                rst_n,
  // Redirect request from the controller
  input  logic                                pc_set_i,
  input  if_fetch_pkg::pc_mux_e               pc_mux_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]     boot_addr_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]     jump_target_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]     branch_target_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]     mepc_i,
  input  logic [if_fetch_pkg::MTVEC_W-1:0]    mtvec_addr_i,
  input  logic [if_fetch_pkg::IRQ_ID_W-1:0]   irq_id_i,
  // Instruction bus
  output logic                                instr_req_o,
  output logic [if_fetch_pkg::ADDR_W-1:0]     instr_addr_o,
  input  logic                                instr_gnt_i,
  input  logic                                instr_rvalid_i,
  input  logic [if_instr_pkg::INSTR_W-1:0]    instr_rdata_i,
  input  logic                                instr_err_i,
  output logic                                busy_o,
  fetch_push_if.fetcher                       push_if
);
  import if_fetch_pkg::*;

  logic [ADDR_W-1:0] target_addr;
  logic [ADDR_W-1:0] aligned_target;
  logic [ADDR_W-1:0] fetch_addr_q;
  logic [ADDR_W-1:0] redir_addr_q;
  logic [ADDR_W-1:0] rsp_addr_q;
  logic              redir_pend_q;
  logic              fetch_en_q;
  logic              held_q;
  logic [CNT_W-1:0]  out_cnt_q;
  logic [CNT_W-1:0]  discard_cnt_q;
  logic              grant;

  //////////////////////////////////////////////////////////////////////
  // Target selection
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     target_addr = boot_addr_i;
      PC_JUMP:     target_addr = jump_target_i;
      PC_BRANCH:   target_addr = branch_target_i;
      PC_MRET:     target_addr = mepc_i;
      // All exceptions share the vector base
      PC_TRAP_EXC: target_addr = {mtvec_addr_i, 7'b0};
      // Vectored interrupts, one word per index
      PC_TRAP_IRQ: target_addr = {mtvec_addr_i, irq_id_i, 2'b00};
      PC_TRAP_NMI: target_addr = {mtvec_addr_i, NMI_INDEX, 2'b00};
      default:     target_addr = boot_addr_i;
    endcase
  end

  // Word fetches only
  assign aligned_target = {target_addr[ADDR_W-1:2], 2'b00};

  //////////////////////////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////////////////////////

  // A waiting request stays up; new ones need a free FIFO slot per outstanding word
  // No new request in a redirect cycle, the address would be stale
  assign instr_req_o  = held_q ||
                        (fetch_en_q && !pc_set_i && (out_cnt_q < push_if.free_cnt));
  assign instr_addr_o = fetch_addr_q;
  assign grant        = instr_req_o && instr_gnt_i;
  assign busy_o       = (out_cnt_q != '0);

  // Responses pass to the FIFO once the stale ones are used up
  assign push_if.push       = instr_rvalid_i && (discard_cnt_q == '0);
  assign push_if.push_addr  = rsp_addr_q;
  assign push_if.push_instr = instr_rdata_i;
  assign push_if.push_err   = instr_err_i;
  assign push_if.flush      = pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q    <= 1'b0;
      held_q        <= 1'b0;
      redir_pend_q  <= 1'b0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      fetch_addr_q  <= '0;
      redir_addr_q  <= '0;
      rsp_addr_q    <= '0;
    end else begin
      held_q    <= instr_req_o && !instr_gnt_i;
      out_cnt_q <= out_cnt_q + CNT_W'(grant) - CNT_W'(instr_rvalid_i);
      if (pc_set_i) begin
        fetch_en_q    <= 1'b1;
        rsp_addr_q    <= aligned_target;
        // Drop every word in flight, a granted or waiting request included
        discard_cnt_q <= out_cnt_q + CNT_W'(instr_req_o) - CNT_W'(instr_rvalid_i);
        if (instr_req_o && !instr_gnt_i) begin
          // Waiting request keeps its address, the target follows after grant
          redir_pend_q <= 1'b1;
          redir_addr_q <= aligned_target;
        end else begin
          redir_pend_q <= 1'b0;
          fetch_addr_q <= aligned_target;
        end
      end else begin
        if (instr_rvalid_i) begin
          if (discard_cnt_q != '0) begin
            discard_cnt_q <= discard_cnt_q - 1'b1;
          end else begin
            rsp_addr_q <= rsp_addr_q + ADDR_W'(4);
          end
        end
        if (grant) begin
          if (redir_pend_q) begin
            redir_pend_q <= 1'b0;
            fetch_addr_q <= redir_addr_q;
          end else begin
            fetch_addr_q <= fetch_addr_q + ADDR_W'(4);
          end
        end
      end
    end
  end

  // Bus rule, request and address held until grant
  a_req_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o)
  ) else $error("instr_addr_o changed while waiting for grant");

endmodule

//--- verilog/if_prefetch_fifo.sv
// Prefetch FIFO holding fetched address, word and bus error, with flush and free-slot count
`timescale 1ns/10ps

module if_prefetch_fifo (
  input  logic       clk,
  input  logic       rst_n,
  fetch_push_if.store push_if,
  fetch_pop_if.store  pop_if
);
  import if_fetch_pkg::*;
  import if_instr_pkg::*;

  logic [ADDR_W-1:0]     addr_mem  [FIFO_DEPTH];
  logic [INSTR_W-1:0]    instr_mem [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] err_mem;
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CNT_W-1:0]      count_q;
  logic                  do_push;
  logic                  do_pop;

  // Flush wins over both ends
  assign do_push = push_if.push && !push_if.flush;
  assign do_pop  = pop_if.pop && pop_if.valid && !push_if.flush;

  // Pending push already claims its slot
  assign push_if.free_cnt = CNT_W'(FIFO_DEPTH) - count_q - CNT_W'(push_if.push);

  assign pop_if.valid = (count_q != '0);
  assign pop_if.addr  = addr_mem[rd_ptr_q];
  assign pop_if.instr = instr_mem[rd_ptr_q];
  assign pop_if.err   = err_mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (do_push) begin
      addr_mem[wr_ptr_q]  <= push_if.push_addr;
      instr_mem[wr_ptr_q] <= push_if.push_instr;
      err_mem[wr_ptr_q]   <= push_if.push_err;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (push_if.flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(do_push);
      rd_ptr_q <= rd_ptr_q + PTR_W'(do_pop);
      count_q  <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  // Fetch controller credit must keep pushes off a full buffer
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    do_push |-> count_q != CNT_W'(FIFO_DEPTH)
  ) else $error("push into full prefetch FIFO");

  // IF/ID side only pops a valid head
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop_if.pop |-> pop_if.valid
  ) else $error("pop from empty prefetch FIFO");

endmodule

//--- verilog/if_id_register.sv
// IF/ID pipeline register with kill/halt gating, stall freeze and compressed marking
`timescale 1ns/10ps

module if_id_register (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              kill_if_i,
  input  logic                              halt_if_i,
  input  logic                              id_ready_i,
  fetch_pop_if.taker                        pop_if,
  output logic                              if_valid_o,
  output logic                              id_instr_valid_o,
  output logic [if_fetch_pkg::ADDR_W-1:0]   id_pc_o,
  output logic [if_instr_pkg::INSTR_W-1:0]  id_instr_o,
  output logic                              id_compressed_o,
  output logic [if_instr_pkg::CINSTR_W-1:0] id_compressed_instr_o,
  output logic                              id_illegal_c_o,
  output logic                              id_bus_err_o
);
  import if_instr_pkg::*;

  quadrant_e quadrant;
  logic      is_compressed;
  logic      illegal_c;

  // Predecode of the head word
  assign quadrant      = quadrant_e'(pop_if.instr[1:0]);
  assign is_compressed = (quadrant != Q_FULL);
  // All-zero 16-bit encoding is reserved as illegal
  assign illegal_c     = is_compressed && (pop_if.instr[CINSTR_W-1:0] == '0);

  // Head visible to ID unless killed or halted
  assign if_valid_o = pop_if.valid && !kill_if_i && !halt_if_i;
  // Kill drains the head without loading it
  assign pop_if.pop = (if_valid_o && id_ready_i) || (kill_if_i && pop_if.valid);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_instr_valid_o      <= 1'b0;
      id_pc_o               <= '0;
      id_instr_o            <= '0;
      id_compressed_o       <= 1'b0;
      id_compressed_instr_o <= '0;
      id_illegal_c_o        <= 1'b0;
      id_bus_err_o          <= 1'b0;
    end else if (if_valid_o && id_ready_i) begin
      id_instr_valid_o <= 1'b1;
      id_pc_o          <= pop_if.addr;
      id_instr_o       <= pop_if.instr;
      id_compressed_o  <= is_compressed;
      id_illegal_c_o   <= illegal_c;
      id_bus_err_o     <= pop_if.err;
      // Low half kept only for compressed words
      if (is_compressed) begin
        id_compressed_instr_o <= pop_if.instr[CINSTR_W-1:0];
      end
    end else if (id_ready_i) begin
      id_instr_valid_o <= 1'b0;
    end
  end

  // Stalled decode sees frozen outputs
  a_stall_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable({id_instr_valid_o, id_pc_o, id_instr_o, id_compressed_o,
                             id_compressed_instr_o, id_illegal_c_o, id_bus_err_o})
  ) else $error("IF/ID outputs changed during stall");

endmodule

//--- verilog/if_stage.sv
// Instruction fetch stage top: fetch controller, prefetch FIFO and IF/ID register
`timescale 1ns/10ps

module if_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  // Controller
  input  logic                              pc_set_i,
  input  if_fetch_pkg::pc_mux_e             pc_mux_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]   boot_addr_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]   jump_target_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]   branch_target_i,
  input  logic [if_fetch_pkg::ADDR_W-1:0]   mepc_i,
  input  logic [if_fetch_pkg::MTVEC_W-1:0]  mtvec_addr_i,
  input  logic [if_fetch_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic                              kill_if_i,
  input  logic                              halt_if_i,
  input  logic                              id_ready_i,
  // Instruction bus
  output logic                              instr_req_o,
  output logic [if_fetch_pkg::ADDR_W-1:0]   instr_addr_o,
  input  logic                              instr_gnt_i,
  input  logic                              instr_rvalid_i,
  input  logic [if_instr_pkg::INSTR_W-1:0]  instr_rdata_i,
  input  logic                              instr_err_i,
  // Status
  output logic                              if_valid_o,
  output logic                              if_busy_o,
  output logic                              csr_mtvec_init_o,
  // IF/ID pipeline
  output logic                              id_instr_valid_o,
  output logic [if_fetch_pkg::ADDR_W-1:0]   id_pc_o,
  output logic [if_instr_pkg::INSTR_W-1:0]  id_instr_o,
  output logic                              id_compressed_o,
  output logic [if_instr_pkg::CINSTR_W-1:0] id_compressed_instr_o,
  output logic                              id_illegal_c_o,
  output logic                              id_bus_err_o
);
  import if_fetch_pkg::*;

  fetch_push_if push_bus ();
  fetch_pop_if  pop_bus ();

  // CSR file loads mtvec on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  if_pc_fetch pc_fetch_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .boot_addr_i     (boot_addr_i),
    .jump_target_i   (jump_target_i),
    .branch_target_i (branch_target_i),
    .mepc_i          (mepc_i),
    .mtvec_addr_i    (mtvec_addr_i),
    .irq_id_i        (irq_id_i),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_err_i     (instr_err_i),
    .busy_o          (if_busy_o),
    .push_if         (push_bus.fetcher)
  );

  if_prefetch_fifo prefetch_fifo_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_if (push_bus.store),
    .pop_if  (pop_bus.store)
  );

  if_id_register id_register_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .kill_if_i             (kill_if_i),
    .halt_if_i             (halt_if_i),
    .id_ready_i            (id_ready_i),
    .pop_if                (pop_bus.taker),
    .if_valid_o            (if_valid_o),
    .id_instr_valid_o      (id_instr_valid_o),
    .id_pc_o               (id_pc_o),
    .id_instr_o            (id_instr_o),
    .id_compressed_o       (id_compressed_o),
    .id_compressed_instr_o (id_compressed_instr_o),
    .id_illegal_c_o        (id_illegal_c_o),
    .id_bus_err_o          (id_bus_err_o)
  );

endmodule

//--- sim/tb_clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  // Free-running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset held low for the first cycles, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

//--- sim/tb_if_stage.sv
// Fetch stage testbench with bus memory responder, controller stimulus, reference model and watchdog
`timescale 1ns/10ps

module tb_if_stage;
  import if_fetch_pkg::*;

  localparam int CLK_PERIOD   = 10;
  localparam int NUM_SEG      = 24;
  localparam int MIN_WORDS    = 4;
  localparam int MAX_WORDS    = 12;
  // Per-word cycle budget covering random grant, delay, stall and halt
  localparam int CYC_PER_WORD = 20;
  localparam int SEG_OVERHEAD = 30;
  localparam int TIMEOUT_NS   =
    (NUM_SEG * (MAX_WORDS * CYC_PER_WORD + SEG_OVERHEAD) + 50) * CLK_PERIOD;
  localparam int MEM_WORDS    = 1024;
  localparam logic [31:0] NMI_SLOT = 32'd15;

  logic        clk;
  logic        rst_n;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  logic [31:0] boot_addr_i;
  logic [31:0] jump_target_i;
  logic [31:0] branch_target_i;
  logic [31:0] mepc_i;
  logic [24:0] mtvec_addr_i;
  logic [4:0]  irq_id_i;
  logic        kill_if_i;
  logic        halt_if_i;
  logic        id_ready_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        if_valid_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;
  logic        id_instr_valid_o;
  logic [31:0] id_pc_o;
  logic [31:0] id_instr_o;
  logic        id_compressed_o;
  logic [15:0] id_compressed_instr_o;
  logic        id_illegal_c_o;
  logic        id_bus_err_o;

  // Memory image and per-word bus error
  logic [31:0] mem_word [MEM_WORDS];
  logic        mem_err  [MEM_WORDS];

  integer      seed;
  int          cyc = 0;
  int          seg_words = 0;
  int          delivered = 0;
  int          checks = 0;
  int          mismatches = 0;
  int          other_errors = 0;
  int          halt_left = 0;
  logic        booted = 1'b0;
  logic        load_pending = 1'b0;
  logic        ready_prev = 1'b0;
  // Stimulus record of a boot redirect in the current cycle
  logic        boot_redirect = 1'b0;
  logic [31:0] exp_addr = '0;
  logic [15:0] exp_chalf = '0;
  logic [31:0] exp_q [$];
  // Granted requests waiting for their response
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q [$];
  logic [31:0] snap_pc;
  logic [31:0] snap_instr;
  logic [19:0] snap_flags;
  pc_mux_e     src;
  int          n_words;
  int          kill_len;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  if_stage if_stage_i (
    .clk                   (clk),
    .rst_n                 (rst_n),
    .pc_set_i              (pc_set_i),
    .pc_mux_i              (pc_mux_i),
    .boot_addr_i           (boot_addr_i),
    .jump_target_i         (jump_target_i),
    .branch_target_i       (branch_target_i),
    .mepc_i                (mepc_i),
    .mtvec_addr_i          (mtvec_addr_i),
    .irq_id_i              (irq_id_i),
    .kill_if_i             (kill_if_i),
    .halt_if_i             (halt_if_i),
    .id_ready_i            (id_ready_i),
    .instr_req_o           (instr_req_o),
    .instr_addr_o          (instr_addr_o),
    .instr_gnt_i           (instr_gnt_i),
    .instr_rvalid_i        (instr_rvalid_i),
    .instr_rdata_i         (instr_rdata_i),
    .instr_err_i           (instr_err_i),
    .if_valid_o            (if_valid_o),
    .if_busy_o             (if_busy_o),
    .csr_mtvec_init_o      (csr_mtvec_init_o),
    .id_instr_valid_o      (id_instr_valid_o),
    .id_pc_o               (id_pc_o),
    .id_instr_o            (id_instr_o),
    .id_compressed_o       (id_compressed_o),
    .id_compressed_instr_o (id_compressed_instr_o),
    .id_illegal_c_o        (id_illegal_c_o),
    .id_bus_err_o          (id_bus_err_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Reference model helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // Word-aligned redirect target for each source
  function automatic logic [31:0] expected_target(input pc_mux_e mux);
    logic [31:0] base;
    logic [31:0] t;
    base = 32'(mtvec_addr_i) << 7;
    case (mux)
      PC_BOOT:     t = boot_addr_i;
      PC_JUMP:     t = jump_target_i;
      PC_BRANCH:   t = branch_target_i;
      PC_MRET:     t = mepc_i;
      PC_TRAP_EXC: t = base;
      PC_TRAP_IRQ: t = base + (32'(irq_id_i) << 2);
      default:     t = base + (NMI_SLOT << 2);
    endcase
    return t & ~32'h3;
  endfunction

  function automatic logic [19:0] id_flags();
    return {id_instr_valid_o, id_compressed_o, id_illegal_c_o, id_bus_err_o,
            id_compressed_instr_o};
  endfunction

  // Word just loaded into IF/ID against memory content at its address
  task automatic check_load(input logic [31:0] a);
    logic [31:0] w;
    logic        comp;
    int          idx;
    idx  = int'(a[11:2]);
    w    = mem_word[idx];
    comp = (w[1:0] != 2'b11);
    if (comp) begin
      exp_chalf = w[15:0];
    end
    check_value("id_instr_valid_o", 32'(id_instr_valid_o), 32'd1);
    check_value("id_pc_o", id_pc_o, a);
    check_value("id_instr_o", id_instr_o, w);
    check_value("id_compressed_o", 32'(id_compressed_o), 32'(comp));
    check_value("id_compressed_instr_o", 32'(id_compressed_instr_o), 32'(exp_chalf));
    check_value("id_illegal_c_o", 32'(id_illegal_c_o), 32'(comp && w[15:0] == 16'h0));
    check_value("id_bus_err_o", 32'(id_bus_err_o), 32'(mem_err[idx]));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus for bus responder and controller on the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic respond_bus();
    logic [31:0] a;
    instr_gnt_i <= (($random(seed) & 1) == 1);
    // In-order responses, at most one per cycle once the delay has run out
    if (rsp_addr_q.size() > 0 && rsp_due_q[0] <= cyc + 1) begin
      a = rsp_addr_q.pop_front();
      void'(rsp_due_q.pop_front());
      instr_rvalid_i <= 1'b1;
      instr_rdata_i  <= mem_word[a[11:2]];
      instr_err_i    <= mem_err[a[11:2]];
    end else begin
      instr_rvalid_i <= 1'b0;
      instr_rdata_i  <= '0;
      instr_err_i    <= 1'b0;
    end
  endtask

  task automatic next_cycle(input logic set, input pc_mux_e mux, input logic kill);
    @(posedge clk);
    respond_bus();
    pc_set_i      <= set;
    pc_mux_i      <= mux;
    kill_if_i     <= kill;
    boot_redirect <= set && (mux == PC_BOOT);
    if (set) begin
      // Low address bits stay random for the stage to clear
      boot_addr_i     <= 32'($random(seed)) & 32'h3ff;
      jump_target_i   <= 32'($random(seed)) & 32'h3ff;
      branch_target_i <= 32'($random(seed)) & 32'h3ff;
      mepc_i          <= 32'($random(seed)) & 32'h3ff;
      mtvec_addr_i    <= 25'($unsigned($random(seed)) % 6);
      irq_id_i        <= 5'($random(seed));
    end
    id_ready_i <= (($random(seed) & 3) != 0);
    // Halt comes in short bursts
    if (halt_left > 0) begin
      halt_left--;
      halt_if_i <= 1'b1;
    end else if (($random(seed) & 15) == 0) begin
      halt_left = 2 + ($random(seed) & 3);
      halt_if_i <= 1'b1;
    end else begin
      halt_if_i <= 1'b0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Monitor sampling on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst_n) begin
      check_value("outputs in reset",
                  32'({instr_req_o, if_valid_o, if_busy_o, id_instr_valid_o}), 32'd0);
      load_pending = 1'b0;
      ready_prev   = 1'b0;
      snap_pc      = id_pc_o;
      snap_instr   = id_instr_o;
      snap_flags   = id_flags();
    end else begin
      cyc = cyc + 1;
      // Effect of the rising edge just passed
      if (load_pending) begin
        check_load(exp_q.pop_front());
      end else if (ready_prev) begin
        check_value("id_instr_valid_o after empty slot", 32'(id_instr_valid_o), 32'd0);
      end else begin
        check_value("id_pc_o during stall", id_pc_o, snap_pc);
        check_value("id_instr_o during stall", id_instr_o, snap_instr);
        check_value("id flags during stall", 32'(id_flags()), 32'(snap_flags));
      end
      check_value("csr_mtvec_init_o", 32'(csr_mtvec_init_o), 32'(boot_redirect));
      if (kill_if_i || halt_if_i) begin
        check_value("if_valid_o under kill or halt", 32'(if_valid_o), 32'd0);
      end
      if (!booted) begin
        check_value("activity before boot", 32'({instr_req_o, if_valid_o, if_busy_o}), 32'd0);
      end
      // Outstanding responses include the one on the bus this cycle
      check_value("if_busy_o", 32'(if_busy_o),
                  32'(rsp_addr_q.size() != 0 || instr_rvalid_i));
      // Queue the response of a granted request with a delay of 1 to 3 cycles
      if (instr_req_o && instr_gnt_i) begin
        if (instr_addr_o[1:0] != 2'b00 || instr_addr_o >= 32'(MEM_WORDS * 4)) begin
          other_errors++;
          $display("error at %0t ns: fetch address %h is unaligned or outside memory",
                   $time, instr_addr_o);
        end
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(cyc + 1 + int'($unsigned($random(seed)) % 3));
      end
      // Redirect restarts the expected stream
      if (pc_set_i) begin
        exp_addr  = expected_target(pc_mux_i);
        seg_words = 0;
        booted    = 1'b1;
      end
      load_pending = if_valid_o && id_ready_i;
      if (load_pending) begin
        exp_q.push_back(exp_addr);
        exp_addr  = exp_addr + 32'd4;
        seg_words++;
        delivered++;
      end
      ready_prev = id_ready_i;
      snap_pc    = id_pc_o;
      snap_instr = id_instr_o;
      snap_flags = id_flags();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed            = 32'h59c2;
    pc_set_i        = 1'b0;
    pc_mux_i        = PC_BOOT;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    mtvec_addr_i    = '0;
    irq_id_i        = '0;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    // Random image with some all-zero low halves
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem_word[i] = $random(seed);
      if (($random(seed) & 7) == 0) begin
        mem_word[i][15:0] = 16'h0000;
      end
      mem_err[i] = (($random(seed) & 15) == 0);
    end
    @(posedge rst_n);
    repeat (3) next_cycle(1'b0, PC_BOOT, 1'b0);
    for (int seg = 0; seg < NUM_SEG; seg++) begin
      // Two passes over every source in order before random picks
      if (seg < 14) begin
        src = pc_mux_e'(3'(seg % 7));
      end else begin
        src = pc_mux_e'(3'($unsigned($random(seed)) % 7));
      end
      n_words = MIN_WORDS + int'($unsigned($random(seed)) % (MAX_WORDS - MIN_WORDS + 1));
      if (seg > 0) begin
        kill_len = $random(seed) & 3;
        repeat (kill_len) next_cycle(1'b0, src, 1'b1);
      end
      // Redirect always comes with kill and may meet requests in flight
      next_cycle(1'b1, src, 1'b1);
      do begin
        next_cycle(1'b0, src, 1'b0);
      end while (seg_words < n_words);
    end
    repeat (6) next_cycle(1'b0, PC_BOOT, 1'b0);
    @(posedge clk);
    $display("checks %0d, mismatches %0d, other errors %0d, words delivered %0d",
             checks, mismatches, other_errors, delivered);
    if (mismatches == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog sized from the longest possible sequence
  initial begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, fetch stage stopped delivering words, %0d delivered",
             TIMEOUT_NS, delivered);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- verilog.f
verilog/if_fetch_pkg.sv
verilog/if_instr_pkg.sv
verilog/if_fetch_intf.sv
verilog/if_pc_fetch.sv
verilog/if_prefetch_fifo.sv
verilog/if_id_register.sv
verilog/if_stage.sv
sim/tb_clock_gen.sv
sim/tb_if_stage.sv

//--- Makefile
# Verilator build and run for the instruction fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_if_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG) || ! grep -q "SIMULATION PASSED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
